// ==== rob_core.f ====
+incdir+src
src/rob_pkg.sv
src/dispatch_stage.sv
src/reorder_buffer.sv
src/exec_unit.sv
src/retire_stage.sv
src/rob_core_top.sv
test/tb_clock_gen.sv
test/rob_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer core testbench with Verilator
# the exit status of the simulation is the test result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rob_core_tb \
    -f rob_core.f -o rob_core_sim

./obj_dir/rob_core_sim

// ==== test/rob_core_tb.sv ====
/*
 * testbench for the reorder buffer core
 * directed and random programs checked against an in-order reference model
 */
`default_nettype none

`include "rob_settings.svh"

module rob_core_tb;

    import rob_pkg::*;

    localparam int PERIOD        = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_INSTR  = 100;
    // 12 alu, 8 reorder, 12 back-pressure, 10 branch
    localparam int TOTAL_INSTR   = 42 + RANDOM_INSTR;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + 200 * TOTAL_INSTR) * PERIOD;
    localparam logic [31:0] SEED = 32'ha8ff8bb6;

    // expected commit plus the opcode that made it
    typedef struct packed {
        op_e     op;
        commit_t result;
    } expect_t;

    logic     clock;
    logic     reset;
    logic     in_valid;
    instr_t   in_instr;
    logic     in_ready;
    logic     commit_valid;
    commit_t  commit;
    logic     commit_ready;
    logic     flush;
    reg_idx_t reg_read_idx;
    data_t    reg_read_data;

    //////////////////////////////
    // reference model state
    //////////////////////////////
    expect_t expected_q [$];
    data_t   model_regs [`ARCH_REGS];
    int      outstanding;
    logic    held_valid;
    commit_t held_commit;

    // commit_ready mode, 0 high, 1 random, 2 low
    int   ready_mode;
    seq_t next_seq;
    int   full_hits;
    int   flush_hits;
    int   equal_branch_hits;

    tb_clock_gen #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    rob_core_top rob_core_top_i (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_ready  (commit_ready),
        .flush         (flush),
        .reg_read_idx  (reg_read_idx),
        .reg_read_data (reg_read_data)
    );

    //////////////////////////////
    // failure reporting
    //////////////////////////////
    task automatic end_with_errors();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic wrong_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("FAIL time %0t signal %s expected %0h actual %0h",
                 $time, name, expected, actual);
        end_with_errors();
    endtask

    task automatic broken_rule(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        end_with_errors();
    endtask

    //////////////////////////////
    // instruction helpers
    //////////////////////////////

    // result straight from the opcode rules
    function automatic expect_t expect_result(input instr_t instr);
        expect_t     e;
        logic [31:0] wide;
        e.op                = instr.op;
        e.result.seq        = instr.seq;
        e.result.has_dest   = instr.has_dest;
        e.result.dest       = instr.dest;
        e.result.mispredict = 1'b0;
        wide = 32'(instr.operand_a) * 32'(instr.operand_b);
        case (instr.op)
            op_add:  e.result.value = instr.operand_a + instr.operand_b;
            op_sub:  e.result.value = instr.operand_a - instr.operand_b;
            op_xor:  e.result.value = instr.operand_a ^ instr.operand_b;
            op_mul:  e.result.value = wide[15:0];
            default: begin
                // branch check, no data
                e.result.value      = '0;
                e.result.mispredict = (instr.operand_a != instr.operand_b);
            end
        endcase
        return e;
    endfunction

    function automatic instr_t make_instr(input op_e op, input data_t a, input data_t b);
        instr_t instr;
        instr.op        = op;
        // branches never write a register
        instr.has_dest  = (op != op_br_check) && ($urandom % 8 != 0);
        instr.dest      = reg_idx_t'($urandom);
        instr.operand_a = a;
        instr.operand_b = b;
        instr.seq       = '0;
        return instr;
    endfunction

    function automatic instr_t alu_instr();
        op_e op;
        op = op_e'($urandom % 3);
        return make_instr(op, data_t'($urandom), data_t'($urandom));
    endfunction

    function automatic instr_t random_instr();
        op_e   op;
        data_t a;
        data_t b;
        op = op_e'($urandom % 5);
        a  = data_t'($urandom);
        b  = data_t'($urandom);
        // half the branches resolve as predicted
        if (op == op_br_check && $urandom % 2 == 0) begin
            b = a;
        end
        return make_instr(op, a, b);
    endfunction

    // offer one instruction, return 2 units after its handshake edge
    task automatic send(input instr_t instr);
        in_instr     = instr;
        in_instr.seq = next_seq;
        in_valid     = 1'b1;
        @(posedge clock);
        while (!in_ready) begin
            @(posedge clock);
        end
        next_seq = next_seq + 1'b1;
        #2;
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    always @(posedge clock) begin
        expect_t head;
        if (reset) begin
            expected_q.delete();
            for (int i = 0; i < `ARCH_REGS; i++) begin
                model_regs[i] = '0;
            end
            full_hits         = 0;
            flush_hits        = 0;
            equal_branch_hits = 0;
        end else begin
            if (commit_valid && commit_ready) begin
                if (expected_q.size() == 0) begin
                    broken_rule("commit with no instruction outstanding");
                end else begin
                    head = expected_q.pop_front();
                    assert (commit.seq == head.result.seq)
                        else wrong_value("commit.seq", 64'(head.result.seq), 64'(commit.seq));
                    assert (commit.has_dest == head.result.has_dest)
                        else wrong_value("commit.has_dest", 64'(head.result.has_dest),
                                         64'(commit.has_dest));
                    assert (commit.dest == head.result.dest)
                        else wrong_value("commit.dest", 64'(head.result.dest),
                                         64'(commit.dest));
                    assert (commit.value == head.result.value)
                        else wrong_value("commit.value", 64'(head.result.value),
                                         64'(commit.value));
                    assert (commit.mispredict == head.result.mispredict)
                        else wrong_value("commit.mispredict", 64'(head.result.mispredict),
                                         64'(commit.mispredict));
                    assert (flush == head.result.mispredict)
                        else wrong_value("flush", 64'(head.result.mispredict), 64'(flush));
                    if (head.result.has_dest) begin
                        model_regs[head.result.dest] = head.result.value;
                    end
                    if (head.result.mispredict) begin
                        // every younger instruction is squashed
                        expected_q.delete();
                        flush_hits++;
                    end else if (head.op == op_br_check) begin
                        equal_branch_hits++;
                    end
                end
            end else begin
                assert (!flush) else wrong_value("flush", 64'd0, 64'(flush));
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(expect_result(in_instr));
            end
            if (outstanding == `ROB_DEPTH) begin
                full_hits++;
            end
        end
        outstanding <= expected_q.size();
    end

    // commit offered but not taken at the last edge
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            held_valid  <= 1'b0;
            held_commit <= '0;
        end else begin
            held_valid  <= commit_valid && !commit_ready;
            held_commit <= commit;
        end
    end

    //////////////////////////////
    // protocol assertions
    //////////////////////////////
    assert property (@(posedge clock) reset |-> !commit_valid)
        else wrong_value("commit_valid", 64'd0, 64'(commit_valid));
    assert property (@(posedge clock) reset |-> !flush)
        else wrong_value("flush", 64'd0, 64'(flush));

    // held commit keeps valid and payload
    assert property (@(posedge clock) disable iff (reset) held_valid |-> commit_valid)
        else wrong_value("commit_valid", 64'd1, 64'(commit_valid));
    assert property (@(posedge clock) disable iff (reset) held_valid |-> commit == held_commit)
        else wrong_value("commit", 64'(held_commit), 64'(commit));

    // no room once every entry is taken
    assert property (@(posedge clock) disable iff (reset)
                     outstanding == `ROB_DEPTH |-> !in_ready)
        else wrong_value("in_ready", 64'd0, 64'(in_ready));

    //////////////////////////////
    // commit_ready driver
    //////////////////////////////
    initial begin
        int mode;
        int low_left;
        commit_ready = 1'b1;
        low_left     = 0;
        forever begin
            @(posedge clock);
            mode = ready_mode;
            #2;
            if (mode == 0) begin
                commit_ready = 1'b1;
            end else if (mode == 2) begin
                commit_ready = 1'b0;
            end else if (low_left > 0) begin
                commit_ready = 1'b0;
                low_left--;
            end else if ($urandom % 6 == 0) begin
                // start a low stretch of 1 to 10 cycles
                commit_ready = 1'b0;
                low_left     = $urandom % 10;
            end else begin
                commit_ready = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        broken_rule("watchdog expired, the core stopped accepting or committing");
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        void'($urandom(SEED));
        in_valid     = 1'b0;
        in_instr     = '0;
        reg_read_idx = '0;
        ready_mode   = 0;
        next_seq     = '0;
        @(negedge reset);
        @(posedge clock);
        #2;

        // plain ALU ops, commit always ready
        for (int i = 0; i < 12; i++) begin
            send(alu_instr());
        end

        // multiply overtaken by faster ALU ops
        for (int i = 0; i < 2; i++) begin
            send(make_instr(op_mul, data_t'($urandom), data_t'($urandom)));
            send(alu_instr());
            send(alu_instr());
            send(alu_instr());
        end

        // commit blocked until the buffer is full, then random
        ready_mode = 2;
        fork
            begin
                idle_cycles(30);
                ready_mode = 1;
            end
            for (int i = 0; i < 12; i++) begin
                send(random_instr());
            end
        join

        // mispredict behind a slow multiply, then a correct branch
        ready_mode = 0;
        send(make_instr(op_mul, 16'd3, 16'd7));
        send(make_instr(op_br_check, 16'd5, 16'd9));
        for (int i = 0; i < 4; i++) begin
            send(alu_instr());
        end
        send(make_instr(op_br_check, 16'h1234, 16'h1234));
        for (int i = 0; i < 3; i++) begin
            send(alu_instr());
        end

        // random mix with gaps and back-pressure
        ready_mode = 1;
        for (int i = 0; i < RANDOM_INSTR; i++) begin
            if ($urandom % 4 == 0) begin
                idle_cycles(1);
            end
            send(random_instr());
        end

        // drain
        ready_mode = 0;
        while (outstanding != 0) begin
            @(posedge clock);
        end
        idle_cycles(2);

        // register file against the model
        for (int i = 0; i < `ARCH_REGS; i++) begin
            reg_read_idx = reg_idx_t'(i);
            @(negedge clock);
            assert (reg_read_data == model_regs[i])
                else wrong_value($sformatf("reg_read_data[%0d]", i),
                                 64'(model_regs[i]), 64'(reg_read_data));
            @(posedge clock);
            #2;
        end

        assert (full_hits > 0) else broken_rule("the reorder buffer never filled");
        assert (flush_hits > 0) else broken_rule("no mispredicted branch was committed");
        assert (equal_branch_hits > 0) else broken_rule("no correct branch was committed");

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
/*
 * testbench clock and reset source
 */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // released just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== src/rob_core_top.sv ====
/*
 * reorder buffer core top level
 * dispatch, reorder buffer, execution and retire wired together
 */
`default_nettype none

module rob_core_top (
    input  wire                clock,
    input  wire                reset,
    input  wire                in_valid,
    input  rob_pkg::instr_t    in_instr,
    output logic               in_ready,
    output logic               commit_valid,
    output rob_pkg::commit_t   commit,
    input  wire                commit_ready,
    output logic               flush,
    input  rob_pkg::reg_idx_t  reg_read_idx,
    output rob_pkg::data_t     reg_read_data
);

    import rob_pkg::*;

    //////////////////////////////
    // internal links
    //////////////////////////////
    logic       alloc_valid;
    logic       alloc_ready;
    rob_entry_t alloc_entry;
    rob_tag_t   alloc_tag;

    logic       issue_valid;
    logic       issue_ready;
    issue_t     issue;

    logic       cdb_valid;
    cdb_t       cdb;

    logic       head_valid;
    logic       head_ready;
    rob_entry_t head_entry;

    dispatch_stage dispatch_stage_i (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .flush       (flush)
    );

    reorder_buffer reorder_buffer_i (
        .clock       (clock),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .head_ready  (head_ready),
        .head_valid  (head_valid),
        .head_entry  (head_entry),
        .flush       (flush)
    );

    exec_unit exec_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .flush       (flush)
    );

    retire_stage retire_stage_i (
        .clock         (clock),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_entry    (head_entry),
        .head_ready    (head_ready),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_ready  (commit_ready),
        .flush         (flush),
        .reg_read_idx  (reg_read_idx),
        .reg_read_data (reg_read_data)
    );

endmodule

`default_nettype wire

// ==== src/retire_stage.sv ====
/*
 * retire stage
 * architectural register file, commit port and flush on mispredict
 */
`default_nettype none

`include "rob_settings.svh"

module retire_stage (
    input  wire                  clock,
    input  wire                  reset,
    // head of the reorder buffer
    input  wire                  head_valid,
    input  rob_pkg::rob_entry_t  head_entry,
    output logic                 head_ready,
    // commit port
    output logic                 commit_valid,
    output rob_pkg::commit_t     commit,
    input  wire                  commit_ready,
    output logic                 flush,
    // register read port
    input  rob_pkg::reg_idx_t    reg_read_idx,
    output rob_pkg::data_t       reg_read_data
);

    import rob_pkg::*;

    localparam int unsigned REGS = `ARCH_REGS;

    data_t regs [REGS];
    logic  commit_fire;

    //////////////////////////////
    // commit port
    //////////////////////////////
    assign commit_valid = head_valid;
    assign head_ready   = commit_ready;
    assign commit_fire  = head_valid && commit_ready;

    always_comb begin
        commit.seq        = head_entry.seq;
        commit.has_dest   = head_entry.has_dest;
        commit.dest       = head_entry.dest;
        commit.value      = head_entry.value;
        commit.mispredict = head_entry.mispredict;
    end

    // only in the cycle the branch actually leaves
    assign flush = commit_fire && head_entry.mispredict;

    //////////////////////////////
    // register file
    //////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_fire && head_entry.has_dest) begin
            regs[head_entry.dest] <= head_entry.value;
        end
    end

    assign reg_read_data = regs[reg_read_idx];

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
/*
 * execution unit
 * one cycle ALU lane, pipelined multiply lane, one shared result bus
 */
`default_nettype none

`include "rob_settings.svh"

module exec_unit (
    input  wire              clock,
    input  wire              reset,
    // issue from dispatch
    input  wire              issue_valid,
    input  rob_pkg::issue_t  issue,
    output logic             issue_ready,
    // common data bus
    output logic             cdb_valid,
    output rob_pkg::cdb_t    cdb,
    input  wire              flush
);

    import rob_pkg::*;

    localparam int unsigned LATENCY = `MUL_LATENCY;
    localparam int unsigned DW = `DATA_WIDTH;

    //////////////////////////////
    // lane state
    //////////////////////////////
    logic alu_valid;
    cdb_t alu_result;
    cdb_t alu_next;

    logic     mul_valid [LATENCY];
    rob_tag_t mul_tag   [LATENCY];
    data_t    mul_value [LATENCY];
    logic [2*DW-1:0] product;

    logic mul_done;
    logic alu_stall;
    logic alu_fire;
    logic mul_fire;

    // multiply owns the bus when both finish
    assign mul_done    = mul_valid[LATENCY-1];
    assign alu_stall   = alu_valid && mul_done;
    assign issue_ready = !alu_stall;

    assign alu_fire = issue_valid && issue_ready && (issue.op != op_mul);
    assign mul_fire = issue_valid && issue_ready && (issue.op == op_mul);

    //////////////////////////////
    // ALU lane
    //////////////////////////////
    always_comb begin
        alu_next.tag        = issue.tag;
        alu_next.mispredict = 1'b0;
        case (issue.op)
            op_add:  alu_next.value = issue.operand_a + issue.operand_b;
            op_sub:  alu_next.value = issue.operand_a - issue.operand_b;
            op_xor:  alu_next.value = issue.operand_a ^ issue.operand_b;
            op_br_check: begin
                // branch yields no data, only the outcome
                alu_next.value      = '0;
                alu_next.mispredict = (issue.operand_a != issue.operand_b);
            end
            default: alu_next.value = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else if (flush) begin
            alu_valid <= 1'b0;
        end else if (alu_fire) begin
            alu_valid <= 1'b1;
        end else if (!alu_stall) begin
            // drained onto the bus this cycle
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_fire) begin
            alu_result <= alu_next;
        end
    end

    //////////////////////////////
    // multiply lane
    //////////////////////////////
    assign product = issue.operand_a * issue.operand_b;

    // valid chain that never stalls
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                mul_valid[i] <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < LATENCY; i++) begin
                mul_valid[i] <= 1'b0;
            end
        end else begin
            mul_valid[0] <= mul_fire;
            for (int i = 1; i < LATENCY; i++) begin
                mul_valid[i] <= mul_valid[i-1];
            end
        end
    end

    // low half of the product rides along
    always_ff @(posedge clock) begin
        mul_tag[0]   <= issue.tag;
        mul_value[0] <= product[DW-1:0];
        for (int i = 1; i < LATENCY; i++) begin
            mul_tag[i]   <= mul_tag[i-1];
            mul_value[i] <= mul_value[i-1];
        end
    end

    //////////////////////////////
    // bus select
    //////////////////////////////
    assign cdb_valid = mul_done || alu_valid;

    always_comb begin
        if (mul_done) begin
            cdb.tag        = mul_tag[LATENCY-1];
            cdb.value      = mul_value[LATENCY-1];
            cdb.mispredict = 1'b0;
        end else begin
            cdb = alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
/*
 * reorder buffer
 * circular entry store, results land by tag and leave in program order
 */
`default_nettype none

`include "rob_settings.svh"

module reorder_buffer (
    input  wire                  clock,
    input  wire                  reset,
    // allocation from dispatch
    input  wire                  alloc_valid,
    input  rob_pkg::rob_entry_t  alloc_entry,
    output logic                 alloc_ready,
    output rob_pkg::rob_tag_t    alloc_tag,
    // common data bus
    input  wire                  cdb_valid,
    input  rob_pkg::cdb_t        cdb,
    // head toward retire
    input  wire                  head_ready,
    output logic                 head_valid,
    output rob_pkg::rob_entry_t  head_entry,
    // committed mispredict
    input  wire                  flush
);

    import rob_pkg::*;

    localparam int unsigned DEPTH = `ROB_DEPTH;
    localparam int unsigned COUNT_WIDTH = $clog2(DEPTH) + 1;

    //////////////////////////////
    // storage and pointers
    //////////////////////////////
    rob_entry_t entries [DEPTH];

    rob_tag_t head;
    rob_tag_t tail;
    // occupancy tells full from empty
    logic [COUNT_WIDTH-1:0] count;

    logic alloc_fire;
    logic retire_fire;

    // wrap-around step
    function automatic rob_tag_t next_tag(input rob_tag_t tag);
        if (tag == rob_tag_t'(DEPTH - 1)) begin
            return '0;
        end
        return tag + 1'b1;
    endfunction

    //////////////////////////////
    // status toward neighbours
    //////////////////////////////
    assign alloc_ready = (count != COUNT_WIDTH'(DEPTH));
    assign alloc_tag   = tail;

    assign head_entry  = entries[head];
    // only a finished entry may leave
    assign head_valid  = (count != '0) && head_entry.complete;

    assign alloc_fire  = alloc_valid && alloc_ready;
    assign retire_fire = head_valid && head_ready;

    //////////////////////////////
    // entry flags and pointers
    //////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].busy     <= 1'b0;
                entries[i].complete <= 1'b0;
            end
        end else if (flush) begin
            // retired mispredict drops all younger work
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].busy     <= 1'b0;
                entries[i].complete <= 1'b0;
            end
        end else begin
            // bus result lands in the tagged slot
            if (cdb_valid && entries[cdb.tag].busy) begin
                entries[cdb.tag].value      <= cdb.value;
                entries[cdb.tag].mispredict <= cdb.mispredict;
                entries[cdb.tag].complete   <= 1'b1;
            end

            // oldest entry leaves
            if (retire_fire) begin
                entries[head].busy     <= 1'b0;
                entries[head].complete <= 1'b0;
                head                   <= next_tag(head);
            end

            // new entry at the tail
            // never the head slot while full
            if (alloc_fire) begin
                entries[tail] <= alloc_entry;
                tail          <= next_tag(tail);
            end

            case ({alloc_fire, retire_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/dispatch_stage.sv ====
/*
 * dispatch stage
 * takes one instruction when both an entry and the execution unit are free
 */
`default_nettype none

module dispatch_stage (
    input  wire                  clock,
    input  wire                  reset,
    // instruction input
    input  wire                  in_valid,
    input  rob_pkg::instr_t      in_instr,
    output logic                 in_ready,
    // allocation toward the reorder buffer
    input  wire                  alloc_ready,
    input  rob_pkg::rob_tag_t    alloc_tag,
    output logic                 alloc_valid,
    output rob_pkg::rob_entry_t  alloc_entry,
    // issue toward execution
    input  wire                  issue_ready,
    output logic                 issue_valid,
    output rob_pkg::issue_t      issue,
    // retire flush
    input  wire                  flush
);

    import rob_pkg::*;

    //////////////////////////////
    // handshake join
    //////////////////////////////

    // all three sides must agree in one cycle
    // no input while a flush empties the buffer
    assign in_ready = alloc_ready && issue_ready && !flush;

    // allocate and issue only on an accepted instruction
    assign alloc_valid = in_valid && in_ready;
    assign issue_valid = in_valid && in_ready;

    //////////////////////////////
    // initial entry
    //////////////////////////////
    always_comb begin
        alloc_entry            = '0;
        // waiting for its result
        alloc_entry.busy       = 1'b1;
        alloc_entry.complete   = 1'b0;
        alloc_entry.has_dest   = in_instr.has_dest;
        alloc_entry.dest       = in_instr.dest;
        alloc_entry.seq        = in_instr.seq;
        alloc_entry.value      = '0;
        alloc_entry.mispredict = 1'b0;
    end

    //////////////////////////////
    // issue packet
    //////////////////////////////
    always_comb begin
        // tag is the tail slot given to this instruction
        issue.tag       = alloc_tag;
        issue.op        = in_instr.op;
        issue.operand_a = in_instr.operand_a;
        issue.operand_b = in_instr.operand_b;
    end

endmodule

`default_nettype wire

// ==== src/rob_pkg.sv ====
/*
 * shared types for the reorder buffer core
 * opcodes, instruction, issue, bus, entry and commit packets
 */
`default_nettype none

`include "rob_settings.svh"

package rob_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;
    // program order number from the source
    typedef logic [7:0] seq_t;

    typedef enum logic [2:0] {
        op_add      = 3'd0,
        op_sub      = 3'd1,
        op_xor      = 3'd2,
        op_mul      = 3'd3,
        // mispredicted when operands differ
        op_br_check = 3'd4
    } op_e;

    //////////////////////////////
    // packets
    //////////////////////////////
    typedef struct packed {
        op_e      op;
        logic     has_dest;
        reg_idx_t dest;
        data_t    operand_a;
        data_t    operand_b;
        seq_t     seq;
    } instr_t;

    // dispatch to execution
    typedef struct packed {
        rob_tag_t tag;
        op_e      op;
        data_t    operand_a;
        data_t    operand_b;
    } issue_t;

    // one result on the common data bus
    typedef struct packed {
        rob_tag_t tag;
        data_t    value;
        logic     mispredict;
    } cdb_t;

    typedef struct packed {
        logic     busy;
        logic     complete;
        logic     has_dest;
        reg_idx_t dest;
        seq_t     seq;
        data_t    value;
        logic     mispredict;
    } rob_entry_t;

    // retired result toward the commit port
    typedef struct packed {
        seq_t     seq;
        logic     has_dest;
        reg_idx_t dest;
        data_t    value;
        logic     mispredict;
    } commit_t;

endpackage

`default_nettype wire

// ==== src/rob_settings.svh ====
/*
 * reorder buffer core sizing
 * depth, register count, data width and multiply pipeline length
 */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// reorder buffer entries, kept a power of two
`define ROB_DEPTH 8

// architectural registers
`define ARCH_REGS 8

// operand and result width
`define DATA_WIDTH 16

// multiply pipeline stages
`define MUL_LATENCY 4

`endif
